// File: common/posit_div_pkg.sv
`default_nettype none

package posit_div_pkg;

    // ######################################################################
    // posit format, P16 with one exponent bit
    // ######################################################################

    localparam int N  = 16;
    localparam int ES = 1;

    localparam int MANT_SIZE            = 14;               // hidden one + 13 fraction bits
    localparam int TE_SIZE              = 7;                // signed, holds te differences
    localparam int MANT_DIV_RESULT_SIZE = 3*MANT_SIZE - 1;
    localparam int RECIP_SIZE           = 3*MANT_SIZE - 4;

    localparam int LUT_WIDTH_IN  = 8;
    localparam int LUT_WIDTH_OUT = 9;

    typedef logic        [N-1:0]                    posit_t;
    typedef logic signed [TE_SIZE-1:0]              te_t;
    typedef logic        [MANT_SIZE-1:0]            mant_t;
    typedef logic        [MANT_DIV_RESULT_SIZE-1:0] mant_q_t;
    typedef logic        [RECIP_SIZE-1:0]           recip_t;

    typedef struct packed {
        logic  sign;
        logic  zero;
        logic  nar;
        te_t   te;
        mant_t mant;
    } decoded_t;

    typedef struct packed {
        logic    sign;
        logic    zero;
        logic    nar;
        te_t     te;
        mant_q_t mant;                                      // bit 40 is the integer bit
    } quot_t;

    // ######################################################################
    // reciprocal table
    // ######################################################################

    typedef logic [2**LUT_WIDTH_IN-1:0][LUT_WIDTH_OUT-1:0] recip_lut_t;

    // entry i = 1 / (1 + (i + 0.5) / 2**IN), scaled by 2**OUT and truncated
    function automatic recip_lut_t make_recip_lut();
        recip_lut_t lut;
        int         num;
        int         den;
        num = 1 << (LUT_WIDTH_OUT + LUT_WIDTH_IN + 1);
        for (int i = 0; i < 2**LUT_WIDTH_IN; i++) begin
            den    = (1 << (LUT_WIDTH_IN + 1)) + 2*i + 1;   // interval midpoint
            lut[i] = LUT_WIDTH_OUT'(num / den);
        end
        return lut;
    endfunction

    localparam recip_lut_t recip_lut = make_recip_lut();

endpackage

`default_nettype wire

// File: hdl/posit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module posit_decoder import posit_div_pkg::*; (
    input  posit_t   p,
    output decoded_t d
);

    posit_t             mag;
    logic [N-2:0]       body;
    logic [4:0]         run;                // regime run length, 1..N-1
    logic signed [5:0]  k;
    logic [N-3:0]       rest;               // exponent then fraction, left aligned
    logic [ES-1:0]      e;

    assign mag  = p[N-1] ? -p : p;
    assign body = mag[N-2:0];

    // ######################################################################
    // leading-run detector
    // ######################################################################

    always_comb begin
        logic run_done;
        run      = 5'd1;
        run_done = 1'b0;
        for (int i = N-3; i >= 0; i--) begin
            if (!run_done && body[i] == body[N-2]) begin
                run = run + 5'd1;
            end else begin
                run_done = 1'b1;
            end
        end
    end

    assign k = body[N-2] ? $signed({1'b0, run}) - 6'sd1   // ones: k = run - 1
                         : -$signed({1'b0, run});         // zeros: k = -run

    // first regime bit is already gone, shift out the rest plus terminator
    assign rest = body[N-3:0] << run;
    assign e    = rest[N-3 -: ES];

    always_comb begin
        d.sign = p[N-1];
        d.zero = (p == '0);
        d.nar  = (p == {1'b1, {(N-1){1'b0}}});
        d.te   = {k, e};                                  // k * 2**ES + e
        d.mant = {1'b1, rest[N-3-ES:0]};
    end

endmodule

`default_nettype wire

// File: posit_div_core/newton_raphson.sv
`timescale 1ns/1ps
`default_nettype none

module newton_raphson import posit_div_pkg::*; (
    input  mant_t                  num,
    input  recip_t                 x0,
    output logic [2*MANT_SIZE-1:0] x1
);

    logic [MANT_SIZE+RECIP_SIZE-1:0]   num_x0;        // 50 fraction bits
    logic [2*MANT_SIZE-1:0]            t;             // 26 fraction bits, about 1.0
    logic [2*MANT_SIZE-1:0]            two_minus;
    logic [RECIP_SIZE+2*MANT_SIZE-1:0] x1_full;       // 63 fraction bits

    assign num_x0 = {{RECIP_SIZE{1'b0}}, num} * {{MANT_SIZE{1'b0}}, x0};
    assign t      = num_x0[MANT_SIZE+RECIP_SIZE-1 -: 2*MANT_SIZE];

    // 2 - num*x0
    assign two_minus = {1'b1, {(2*MANT_SIZE-1){1'b0}}} - t;

    assign x1_full = {{(2*MANT_SIZE){1'b0}}, x0} * {{RECIP_SIZE{1'b0}}, two_minus};

    // integer bit plus 27 fraction bits
    assign x1 = x1_full[2*MANT_SIZE+RECIP_SIZE-3 -: 2*MANT_SIZE];

endmodule

`default_nettype wire

// File: posit_div_core/core_div.sv
`timescale 1ns/1ps
`default_nettype none

module core_div import posit_div_pkg::*; (
    input  decoded_t a,
    input  decoded_t b,
    output quot_t    q
);

    te_t                      te_diff;
    logic [LUT_WIDTH_IN-1:0]  lut_addr;
    logic [LUT_WIDTH_OUT-1:0] lut_out;
    recip_t                   x0;
    logic [2*MANT_SIZE-1:0]   x1;
    mant_q_t                  mant_div;
    logic                     below_one;
    logic                     nar;

    assign te_diff = a.te - b.te;

    // ######################################################################
    // divisor reciprocal
    // ######################################################################

    assign lut_addr = b.mant[MANT_SIZE-2 -: LUT_WIDTH_IN];    // bits under the hidden one
    assign lut_out  = recip_lut[lut_addr];

    // 37 fraction bits, top bit stays clear
    assign x0 = {lut_out, {(RECIP_SIZE-LUT_WIDTH_OUT){1'b0}}} >> 1;

    newton_raphson u_nr (
        .num (b.mant),
        .x0  (x0),
        .x1  (x1)
    );

    // ######################################################################
    // quotient mantissa
    // ######################################################################

    // 13 + 27 fraction bits, result in (0.5, 2)
    assign mant_div  = mant_q_t'(a.mant) * mant_q_t'(x1);
    assign below_one = ~mant_div[MANT_DIV_RESULT_SIZE-1];

    assign nar = a.nar | b.nar | b.zero;

    always_comb begin
        q.nar  = nar;
        q.zero = ~nar & a.zero;
        q.sign = a.sign ^ b.sign;
        q.te   = below_one ? te_diff - te_t'(1) : te_diff;
        q.mant = below_one ? mant_div << 1 : mant_div;        // at most one position
    end

endmodule

`default_nettype wire

// File: hdl/posit_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module posit_encoder import posit_div_pkg::*; (
    input  quot_t  q,
    output posit_t p
);

    localparam int W = MANT_DIV_RESULT_SIZE + N + ES;   // regime seed, e, fraction, spare

    logic signed [TE_SIZE-ES-1:0] k;
    logic [ES-1:0]                e;
    logic                         r0;
    logic [$clog2(N)-1:0]         shamt;
    logic [W-1:0]                 bits;
    logic [W-1:0]                 bits_sh;
    logic [N-2:0]                 body;
    logic                         guard;
    logic                         sticky;
    logic                         round_up;
    logic [N-2:0]                 mag;
    logic [N-2:0]                 mag_sat;
    logic                         sat_hi;
    logic                         sat_lo;

    assign k  = q.te[TE_SIZE-1:ES];                     // te >>> ES
    assign e  = q.te[ES-1:0];
    assign r0 = ~k[TE_SIZE-ES-1];                       // ones for k >= 0

    // ######################################################################
    // regime run
    // ######################################################################

    // run length minus one: k for k >= 0, -k-1 otherwise
    assign shamt = r0 ? k[$clog2(N)-1:0] : ~k[$clog2(N)-1:0];

    assign bits = {r0, ~r0, e, q.mant[MANT_DIV_RESULT_SIZE-2:0], {(N-1){1'b0}}};

    // sign fill extends the regime run
    assign bits_sh = $signed(bits) >>> shamt;

    assign sat_hi = (int'(k) > N-3);
    assign sat_lo = (int'(k) < -(N-2));

    // ######################################################################
    // round to nearest even
    // ######################################################################

    assign body     = bits_sh[W-1 -: N-1];
    assign guard    = bits_sh[W-N];
    assign sticky   = |bits_sh[W-N-1:0];
    assign round_up = guard & (sticky | body[0]);

    // carry may ripple into exponent and regime
    assign mag = body + {{(N-2){1'b0}}, round_up};

    always_comb begin
        if (sat_hi) begin
            mag_sat = {(N-1){1'b1}};                    // maxpos
        end else if (sat_lo) begin
            mag_sat = {{(N-2){1'b0}}, 1'b1};            // minpos
        end else begin
            mag_sat = mag;
        end
    end

    always_comb begin
        if (q.nar) begin
            p = {1'b1, {(N-1){1'b0}}};
        end else if (q.zero) begin
            p = '0;
        end else if (q.sign) begin
            p = -{1'b0, mag_sat};
        end else begin
            p = {1'b0, mag_sat};
        end
    end

endmodule

`default_nettype wire

// File: hdl/posit_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module posit_div_top import posit_div_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    input  posit_t dividend,
    input  posit_t divisor,
    output logic   out_valid,
    output posit_t quotient
);

    decoded_t dec_a;
    decoded_t dec_b;
    decoded_t dec_a_r;
    decoded_t dec_b_r;
    logic     valid_r;
    quot_t    quot;
    posit_t   enc;

    posit_decoder u_dec_a (
        .p (dividend),
        .d (dec_a)
    );

    posit_decoder u_dec_b (
        .p (divisor),
        .d (dec_b)
    );

    // ######################################################################
    // stage 1, decoded operands
    // ######################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_a_r <= dec_a;
            dec_b_r <= dec_b;
        end
    end

    core_div u_core (
        .a (dec_a_r),
        .b (dec_b_r),
        .q (quot)
    );

    posit_encoder u_enc (
        .q (quot),
        .p (enc)
    );

    // ######################################################################
    // stage 2, packed result
    // ######################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            quotient  <= '0;
        end else begin
            out_valid <= valid_r;
            if (valid_r) begin
                quotient <= enc;                        // held between results
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_posit_div_model.svh
`ifndef TB_POSIT_DIV_MODEL_SVH
`define TB_POSIT_DIV_MODEL_SVH

localparam int FRAC_MAX = N - 3 - ES;                   // longest fraction field

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// sign, scale and significand with FRAC_MAX fraction bits
function automatic void decode_posit(input posit_t p, output logic sign,
                                     output int scale, output longint sig);
    posit_t mag;
    int     run;
    int     rem;
    int     fb;
    sign = p[N-1];
    mag  = sign ? -p : p;
    run  = 1;
    while (run < N-1 && mag[N-2-run] == mag[N-2]) begin
        run++;
    end
    scale = mag[N-2] ? 2*(run-1) : -2*run;
    rem   = (run >= N-2) ? 0 : N-2-run;                 // bits after the terminator
    if (rem > 0) begin
        scale = scale + int'(mag[rem-1]);
    end
    fb  = (rem > ES) ? rem - ES : 0;
    sig = (longint'(1) << FRAC_MAX)
        | ((longint'(mag) & ((longint'(1) << fb) - longint'(1))) << (FRAC_MAX - fb));
endfunction

// exact long division, then round to nearest even on the posit bit string
function automatic posit_t div_ref(input posit_t a, input posit_t b);
    logic   sa;
    logic   sb;
    logic   stk;
    logic   guard;
    int     ea;
    int     eb;
    int     scale;
    int     k;
    int     len;
    longint ma;
    longint mb;
    longint q;
    longint str;
    longint body;
    if (a == NAR || b == NAR || b == '0) begin
        return NAR;
    end
    if (a == '0) begin
        return '0;
    end
    decode_posit(a, sa, ea, ma);
    decode_posit(b, sb, eb, mb);
    scale = ea - eb;
    q     = (ma << 40) / mb;
    stk   = ((ma << 40) % mb) != '0;
    if (q < (longint'(1) << 40)) begin                  // quotient below one
        q     = q << 1;
        scale = scale - 1;
    end
    k = scale >>> 1;
    if (k < -(N-2)) begin
        return (sa ^ sb) ? -MINPOS : MINPOS;
    end
    if (k > N-2) begin
        k = N-2;                                        // rounds down to maxpos
    end
    if (k >= 0) begin
        str = ((longint'(1) << (k + 1)) - longint'(1)) << 1;
        len = k + 2;
    end else begin
        str = longint'(1);
        len = 1 - k;
    end
    str   = (str << 1) | longint'(scale & 1);
    str   = (str << 40) | (q & ((longint'(1) << 40) - longint'(1)));
    len   = len + 1 + 40;
    body  = str >> (len - (N-1));
    guard = ((str >> (len - N)) & longint'(1)) != '0;
    stk   = stk | ((str & ((longint'(1) << (len - N)) - longint'(1))) != '0);
    if (guard && (stk || body[0])) begin
        body = body + longint'(1);
    end
    if (body > longint'(MAXPOS)) begin
        body = longint'(MAXPOS);
    end
    return (sa ^ sb) ? -posit_t'(body) : posit_t'(body);
endfunction

`endif

// File: testbench/tb_posit_div.sv
`timescale 1ns/1ps
`default_nettype none

module tb_posit_div import posit_div_pkg::*; ();

    localparam int     LATENCY = 2;                     // drive edge to result
    localparam posit_t NAR     = 16'h8000;
    localparam posit_t ONE     = 16'h4000;
    localparam posit_t MAXPOS  = 16'h7fff;
    localparam posit_t MINPOS  = 16'h0001;
    localparam posit_t POW4 [5] = '{16'h1000, 16'h2000, 16'h4000, 16'h6000, 16'h7000};

    typedef struct packed {
        posit_t      a;
        posit_t      b;
        posit_t      q;
        logic        near;                              // one code of slack
        logic [31:0] due;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    posit_t      dividend;
    posit_t      divisor;
    logic        out_valid;
    posit_t      quotient;
    logic [31:0] lfsr;
    logic [31:0] cycle = '0;
    expect_t     exp_q [$];

    `include "tb_posit_div_model.svh"

    posit_div_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .quotient  (quotient)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic posit_t rand_operand();
        posit_t p;
        p = posit_t'(rand_bits(N));
        while (p == '0 || p == NAR) begin
            p = posit_t'(rand_bits(N));
        end
        return p;
    endfunction

    task automatic issue(input posit_t a, input posit_t b, input logic near);
        expect_t e;
        @(posedge clk);
        in_valid <= 1'b1;
        dividend <= a;
        divisor  <= b;
        e.a    = a;
        e.b    = b;
        e.q    = div_ref(a, b);
        e.near = near;
        e.due  = cycle + 32'd1 + 32'(LATENCY);
        exp_q.push_back(e);
    endtask

    // ######################################################################
    // compare at mid cycle
    // ######################################################################

    always @(negedge clk) begin
        expect_t e;
        int      diff;
        if (out_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                stop_with_error("out_valid went high with no operation in flight");
            end else begin
                e = exp_q.pop_front();
                check("out_valid cycle", cycle, e.due);
                if (!e.near) begin
                    check("quotient", 32'(quotient), 32'(e.q));
                end else begin
                    diff = int'($signed(quotient)) - int'($signed(e.q));
                    if (diff > 1 || diff < -1) begin
                        stop_with_error($sformatf("FAIL quotient: got 0x%0h, expected 0x%0h",
                                                  quotient, e.q));
                    end
                    check("quotient sign", 32'(quotient[N-1]), 32'(e.a[N-1] ^ e.b[N-1]));
                    if (quotient == '0 || quotient == NAR) begin
                        stop_with_error("a nonzero quotient came out as zero or NaR");
                    end
                end
            end
        end
    end

    initial begin
        posit_t x;
        int     timeout;
        lfsr     = 32'd72178;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        dividend = '0;
        divisor  = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("out_valid", 32'(out_valid), 32'd0);
        check("quotient", 32'(quotient), 32'd0);

        issue(16'h3000, '0, 1'b0);                      // x/0
        issue('0, '0, 1'b0);
        issue(NAR, ONE, 1'b0);
        issue(16'hc123, NAR, 1'b0);
        issue(NAR, NAR, 1'b0);
        issue('0, 16'h9abc, 1'b0);
        issue('0, MINPOS, 1'b0);
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                issue(POW4[i], POW4[j], 1'b0);
            end
        end
        for (int i = 0; i < 40; i++) begin
            x = rand_operand();
            issue(x, ONE, 1'b0);
            issue(x, x, 1'b0);
        end
        issue(MAXPOS, MINPOS, 1'b0);                    // saturation
        issue(MINPOS, MAXPOS, 1'b0);
        issue(-MAXPOS, MINPOS, 1'b0);
        issue(MINPOS, -MAXPOS, 1'b0);
        for (int i = 0; i < 2000; i++) begin
            issue(rand_operand(), rand_operand(), 1'b1);
        end
        @(posedge clk);
        in_valid <= 1'b0;

        timeout = 0;
        while (exp_q.size() != 0 && timeout < 10) begin
            @(posedge clk);
            timeout++;
        end
        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_error("timed out waiting for the last results");
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
common/posit_div_pkg.sv
hdl/posit_decoder.sv
posit_div_core/newton_raphson.sv
posit_div_core/core_div.sv
hdl/posit_encoder.sv
hdl/posit_div_top.sv
testbench/tb_posit_div.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_posit_div
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
